// File: source/core_cfg_pkg.sv
// Core configuration
// Machine widths and storage types shared by every stage of the RV32I pipeline

`default_nettype none

package core_cfg_pkg;

    localparam int XLEN     = 32;   // Integer data width
    localparam int NUM_REGS = 32;   // Architectural integer registers

    // Data word held in registers and produced by the ALU
    typedef logic [XLEN-1:0] word_t;

    // Byte address of an instruction
    typedef logic [XLEN-1:0] pc_t;

    // Raw instruction word, fixed by the ISA
    typedef logic [31:0] instr_t;

    // Register index
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: source/rv_isa_pkg.sv
// RV32I encodings
// Opcodes and funct3 codes of the supported instructions, plus the internal
// ALU operation codes

`default_nettype none

package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OP_REG = 7'b0110011;   // Register-register ALU
    localparam logic [6:0] OP_IMM = 7'b0010011;   // Register-immediate ALU
    localparam logic [6:0] OP_LUI = 7'b0110111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;      // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;      // SRL and SRA, split by funct7[5]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // ALU operation selected in decode
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

endpackage

`default_nettype wire

// File: source/id_ex_if.sv
// ID/EX bundle
// Decoded instruction as held in the ID/EX register, from decode to execute

`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;

    core_cfg_pkg::word_t     rs1_data;
    core_cfg_pkg::word_t     rs2_data;
    core_cfg_pkg::word_t     imm;
    core_cfg_pkg::reg_addr_t rs1_addr;    // Source indexes for forwarding
    core_cfg_pkg::reg_addr_t rs2_addr;
    core_cfg_pkg::reg_addr_t rd_addr;
    rv_isa_pkg::alu_op_t     alu_op;
    logic                    use_imm;     // Second operand is imm
    logic                    is_lui;
    logic                    reg_write;

    // Decode side owns the register
    modport dec (
        output rs1_data, rs2_data, imm, rs1_addr, rs2_addr, rd_addr,
        output alu_op, use_imm, is_lui, reg_write
    );

    modport exe (
        input rs1_data, rs2_data, imm, rs1_addr, rs2_addr, rd_addr,
        input alu_op, use_imm, is_lui, reg_write
    );

endinterface

`default_nettype wire

// File: source/fetch_unit.sv
// Fetch unit
// Program counter, loadable instruction memory and the IF/ID instruction
// register. The PC steps by 4 on every enabled cycle

`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int IMEM_ADDR_WIDTH = 6
) (
    input  wire logic                         clk,
    input  wire logic                         i_rst,
    input  wire logic                         i_en,
    input  wire logic                         i_imem_wen,
    input  wire logic [IMEM_ADDR_WIDTH-1:0]   i_imem_waddr,
    input  wire core_cfg_pkg::instr_t         i_imem_data,
    output core_cfg_pkg::pc_t                 o_pc,
    output core_cfg_pkg::instr_t              o_instr
);

    localparam int IMEM_DEPTH = 2 ** IMEM_ADDR_WIDTH;

    core_cfg_pkg::instr_t imem [0:IMEM_DEPTH-1];
    core_cfg_pkg::instr_t fetch_word;

    // Word-addressed, so the two byte-offset bits are dropped
    assign fetch_word = imem[o_pc[IMEM_ADDR_WIDTH+1:2]];

    // Load port
    always_ff @(posedge clk) begin
        if (i_imem_wen) begin
            imem[i_imem_waddr] <= i_imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pc    <= '0;
            o_instr <= '0;                  // All-zero word decodes as a no-op
        end else if (i_en) begin
            o_pc    <= o_pc + 32'd4;
            o_instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

// File: source/int_regfile.sv
// Integer register file
// 31 writable registers with x0 hardwired to zero. Both read ports see a
// write from the same cycle. A registered debug port reads any register

`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  wire logic                      clk,
    input  wire logic                      i_rst,
    input  wire core_cfg_pkg::reg_addr_t   i_rs1_addr,
    input  wire core_cfg_pkg::reg_addr_t   i_rs2_addr,
    input  wire logic                      i_we,
    input  wire core_cfg_pkg::reg_addr_t   i_rd,
    input  wire core_cfg_pkg::word_t       i_wdata,
    input  wire logic                      i_dbg_rd,
    input  wire core_cfg_pkg::reg_addr_t   i_dbg_addr,
    output core_cfg_pkg::word_t            o_rs1_data,
    output core_cfg_pkg::word_t            o_rs2_data,
    output core_cfg_pkg::word_t            o_dbg_data
);

    core_cfg_pkg::word_t regs [1:core_cfg_pkg::NUM_REGS-1];

    // Read with x0 forced to zero and the pending write passed through
    function automatic core_cfg_pkg::word_t read_reg(input core_cfg_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_we && (i_rd == addr)) begin
            return i_wdata;
        end
        return regs[addr];
    endfunction

    assign o_rs1_data = read_reg(i_rs1_addr);
    assign o_rs2_data = read_reg(i_rs2_addr);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < core_cfg_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            o_dbg_data <= '0;
        end else begin
            if (i_we && (i_rd != '0)) begin
                regs[i_rd] <= i_wdata;    // Writes to x0 are dropped here
            end
            if (i_dbg_rd) begin
                o_dbg_data <= read_reg(i_dbg_addr);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
// Decode stage
// Splits the instruction, decodes control and ALU operation, builds the
// immediate and reads the register file into the ID/EX register

`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                      clk,
    input  wire logic                      i_rst,
    input  wire logic                      i_en,
    input  wire core_cfg_pkg::instr_t      i_instr,
    input  wire logic                      i_wb_we,
    input  wire core_cfg_pkg::reg_addr_t   i_wb_rd,
    input  wire core_cfg_pkg::word_t       i_wb_data,
    input  wire logic                      i_dbg_rd,
    input  wire core_cfg_pkg::reg_addr_t   i_dbg_addr,
    output core_cfg_pkg::word_t            o_dbg_data,
    id_ex_if.dec                           ex
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    core_cfg_pkg::reg_addr_t   rs1_addr;
    core_cfg_pkg::reg_addr_t   rs2_addr;
    core_cfg_pkg::reg_addr_t   rd_addr;
    core_cfg_pkg::word_t       rs1_data;
    core_cfg_pkg::word_t       rs2_data;
    core_cfg_pkg::word_t       imm;
    rv_isa_pkg::alu_op_t       alu_op;
    logic                      use_imm;
    logic                      is_lui;
    logic                      reg_write;

    // Instruction fields
    assign opcode   = i_instr[6:0];
    assign rd_addr  = i_instr[11:7];
    assign funct3   = i_instr[14:12];
    assign rs1_addr = i_instr[19:15];
    assign rs2_addr = i_instr[24:20];
    assign funct7   = i_instr[31:25];

    // alt selects SUB or SRA on the codes that have a second form
    function automatic rv_isa_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_isa_pkg::F3_ADD:  return alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  return rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  return rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: return rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  return rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   return alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   return rv_isa_pkg::ALU_OR;
            default:             return rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        reg_write = 1'b0;               // Unknown opcodes retire as no-ops
        use_imm   = 1'b0;
        is_lui    = 1'b0;
        alu_op    = rv_isa_pkg::ALU_ADD;
        imm       = {{20{i_instr[31]}}, i_instr[31:20]};   // I-type
        case (opcode)
            rv_isa_pkg::OP_REG: begin
                reg_write = 1'b1;
                alu_op    = alu_decode(funct3, funct7[5]);
            end
            rv_isa_pkg::OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                // Only SRAI uses funct7, ADDI has no subtract form
                alu_op    = alu_decode(funct3, (funct3 == rv_isa_pkg::F3_SR) && funct7[5]);
            end
            rv_isa_pkg::OP_LUI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                is_lui    = 1'b1;
                imm       = {i_instr[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    int_regfile u_regfile (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_we       (i_wb_we),
        .i_rd       (i_wb_rd),
        .i_wdata    (i_wb_data),
        .i_dbg_rd   (i_dbg_rd),
        .i_dbg_addr (i_dbg_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_dbg_data (o_dbg_data)
    );

    // ID/EX control
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ex.reg_write <= 1'b0;
            ex.use_imm   <= 1'b0;
            ex.is_lui    <= 1'b0;
            ex.alu_op    <= rv_isa_pkg::ALU_ADD;
        end else if (i_en) begin
            ex.reg_write <= reg_write;
            ex.use_imm   <= use_imm;
            ex.is_lui    <= is_lui;
            ex.alu_op    <= alu_op;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (i_en) begin
            ex.rs1_data <= rs1_data;
            ex.rs2_data <= rs2_data;
            ex.imm      <= imm;
            ex.rs1_addr <= rs1_addr;
            ex.rs2_addr <= rs2_addr;
            ex.rd_addr  <= rd_addr;
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
// Execute stage
// Forwards the writeback result into the operands, picks the immediate
// when asked and runs the ALU. Purely combinational

`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    id_ex_if.exe                           ex,
    input  wire logic                      i_fwd_we,
    input  wire core_cfg_pkg::reg_addr_t   i_fwd_rd,
    input  wire core_cfg_pkg::word_t       i_fwd_data,
    output core_cfg_pkg::word_t            o_alu_result,
    output core_cfg_pkg::reg_addr_t        o_rd,
    output logic                           o_reg_write,
    output logic                           o_is_lui,
    output core_cfg_pkg::word_t            o_imm
);

    logic                  fwd_a;
    logic                  fwd_b;
    core_cfg_pkg::word_t   op_a;
    core_cfg_pkg::word_t   rs2_val;
    core_cfg_pkg::word_t   op_b;
    logic [4:0]            shamt;

    // x0 never forwards, its value is always zero
    assign fwd_a = i_fwd_we && (i_fwd_rd != '0) && (i_fwd_rd == ex.rs1_addr);
    assign fwd_b = i_fwd_we && (i_fwd_rd != '0) && (i_fwd_rd == ex.rs2_addr);

    assign op_a    = fwd_a ? i_fwd_data : ex.rs1_data;
    assign rs2_val = fwd_b ? i_fwd_data : ex.rs2_data;
    assign op_b    = ex.use_imm ? ex.imm : rs2_val;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (ex.alu_op)
            rv_isa_pkg::ALU_ADD:  o_alu_result = op_a + op_b;
            rv_isa_pkg::ALU_SUB:  o_alu_result = op_a - op_b;
            rv_isa_pkg::ALU_SLL:  o_alu_result = op_a << shamt;
            rv_isa_pkg::ALU_SLT:  o_alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_SLTU: o_alu_result = {31'b0, op_a < op_b};
            rv_isa_pkg::ALU_XOR:  o_alu_result = op_a ^ op_b;
            rv_isa_pkg::ALU_SRL:  o_alu_result = op_a >> shamt;
            rv_isa_pkg::ALU_SRA:  o_alu_result = $signed(op_a) >>> shamt;   // Sign fill
            rv_isa_pkg::ALU_OR:   o_alu_result = op_a | op_b;
            rv_isa_pkg::ALU_AND:  o_alu_result = op_a & op_b;
            default:              o_alu_result = '0;
        endcase
    end

    // Writeback fields travel on to the EX/WB register
    assign o_rd        = ex.rd_addr;
    assign o_reg_write = ex.reg_write;
    assign o_is_lui    = ex.is_lui;
    assign o_imm       = ex.imm;

endmodule

`default_nettype wire

// File: source/result_stage.sv
// Result stage
// Chooses the final value and holds the EX/WB register that drives the
// register write and the forward path

`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic                      clk,
    input  wire logic                      i_rst,
    input  wire logic                      i_en,
    input  wire core_cfg_pkg::word_t       i_alu_result,
    input  wire core_cfg_pkg::reg_addr_t   i_rd,
    input  wire logic                      i_reg_write,
    input  wire logic                      i_is_lui,
    input  wire core_cfg_pkg::word_t       i_imm,
    output logic                           o_wb_we,
    output core_cfg_pkg::reg_addr_t        o_wb_rd,
    output core_cfg_pkg::word_t            o_wb_data
);

    logic wb_reg_write;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wb_reg_write <= 1'b0;
            o_wb_rd      <= '0;
            o_wb_data    <= '0;
        end else if (i_en) begin
            wb_reg_write <= i_reg_write;
            o_wb_rd      <= i_rd;
            o_wb_data    <= i_is_lui ? i_imm : i_alu_result;   // LUI takes the upper immediate
        end
    end

    // No write on a frozen cycle
    assign o_wb_we = wb_reg_write & i_en;

endmodule

`default_nettype wire

// File: source/cpu_core.sv
// RV32I core top level
// Four-stage integer pipeline (IF, ID, EX, WB) with a loadable
// instruction memory, a freeze input and a register debug port

`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int IMEM_ADDR_WIDTH = 6    // Word-address width of the instruction memory
) (
    input  wire logic                         clk,
    input  wire logic                         i_rst,
    input  wire logic                         i_en,
    input  wire logic                         i_imem_wen,
    input  wire logic [IMEM_ADDR_WIDTH-1:0]   i_imem_waddr,
    input  wire core_cfg_pkg::instr_t         i_imem_data,
    input  wire logic                         i_dbg_rd,
    input  wire core_cfg_pkg::reg_addr_t      i_dbg_addr,
    output core_cfg_pkg::pc_t                 o_pc,
    output core_cfg_pkg::word_t               o_dbg_data
);

    core_cfg_pkg::instr_t      if_id_instr;
    core_cfg_pkg::word_t       ex_alu_result;
    core_cfg_pkg::reg_addr_t   ex_rd;
    logic                      ex_reg_write;
    logic                      ex_is_lui;
    core_cfg_pkg::word_t       ex_imm;
    logic                      wb_we;         // Writeback bus, also the forward source
    core_cfg_pkg::reg_addr_t   wb_rd;
    core_cfg_pkg::word_t       wb_data;

    id_ex_if u_id_ex ();

    fetch_unit #(
        .IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH)
    ) u_fetch (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_imem_wen   (i_imem_wen),
        .i_imem_waddr (i_imem_waddr),
        .i_imem_data  (i_imem_data),
        .o_pc         (o_pc),
        .o_instr      (if_id_instr)
    );

    decode_stage u_decode (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_en       (i_en),
        .i_instr    (if_id_instr),
        .i_wb_we    (wb_we),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data),
        .i_dbg_rd   (i_dbg_rd),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data),
        .ex         (u_id_ex.dec)
    );

    execute_stage u_execute (
        .ex           (u_id_ex.exe),
        .i_fwd_we     (wb_we),
        .i_fwd_rd     (wb_rd),
        .i_fwd_data   (wb_data),
        .o_alu_result (ex_alu_result),
        .o_rd         (ex_rd),
        .o_reg_write  (ex_reg_write),
        .o_is_lui     (ex_is_lui),
        .o_imm        (ex_imm)
    );

    result_stage u_result (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_alu_result (ex_alu_result),
        .i_rd         (ex_rd),
        .i_reg_write  (ex_reg_write),
        .i_is_lui     (ex_is_lui),
        .i_imm        (ex_imm),
        .o_wb_we      (wb_we),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// File: tb/cpu_core_chk.sv
// Core protocol checks
// PC stepping, PC hold while the core is frozen and PC clear on reset

`timescale 1ns/1ps
`default_nettype none

module cpu_core_chk (
    input wire logic        clk,
    input wire logic        i_rst,
    input wire logic        i_en,
    input wire logic [31:0] i_pc
);

    int fail_count = 0;

    pc_step: assert property (@(posedge clk) disable iff (i_rst)
        i_en |=> i_pc == $past(i_pc) + 32'd4)
        else begin
            fail_count++;
            $error("PC did not step by 4 on an enabled edge");
        end

    pc_hold: assert property (@(posedge clk) disable iff (i_rst)
        !i_en |=> $stable(i_pc))
        else begin
            fail_count++;
            $error("PC moved on a frozen edge");
        end

    pc_reset: assert property (@(posedge clk) i_rst |=> i_pc == 32'd0)
        else begin
            fail_count++;
            $error("PC not cleared by reset");
        end

endmodule

bind cpu_core cpu_core_chk u_chk (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_en    (i_en),
    .i_pc    (o_pc)
);

`default_nettype wire

// File: tb/cpu_core_tb.sv
// Testbench for the RV32I pipeline
// Runs a random program once freely and once with random freeze cycles,
// then compares every register with a sequential ISA model

`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

    localparam int PROG_LEN   = 40;
    localparam int MEM_WORDS  = 64;
    localparam int RUN_CYCLES = PROG_LEN + 4;     // Last instruction retires after 3 more edges
    localparam int FREEZE_MAX = 40;
    localparam int RST_CYCLES = 16;
    // Two resets, load, two runs, frozen cycles, three readbacks and a margin
    localparam int TIMEOUT = 2 * RST_CYCLES + MEM_WORDS + 2 * RUN_CYCLES + FREEZE_MAX
                             + 3 * 32 + 50;

    // Model op order: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    localparam logic [2:0] F3_OF [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                          3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam int         I_OP  [9]  = '{0, 3, 4, 5, 8, 9, 2, 6, 7};   // ADDI .. SRAI

    logic        clk;
    logic        i_rst, i_en, i_imem_wen, i_dbg_rd;
    logic [5:0]  i_imem_waddr;
    logic [31:0] i_imem_data;
    logic [4:0]  i_dbg_addr;
    logic [31:0] o_pc;
    logic [31:0] o_dbg_data;

    logic [31:0] seed = 32'h7524_0cd7;
    logic [31:0] prog [0:MEM_WORDS-1];
    logic [31:0] model_regs [0:31];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    cpu_core #(
        .IMEM_ADDR_WIDTH (6)
    ) dut (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_imem_wen   (i_imem_wen),
        .i_imem_waddr (i_imem_waddr),
        .i_imem_data  (i_imem_data),
        .i_dbg_rd     (i_dbg_rd),
        .i_dbg_addr   (i_dbg_addr),
        .o_pc         (o_pc),
        .o_dbg_data   (o_dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Mostly x0..x5 so that neighbours depend on each other
    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        return (r[2:0] < 3'd6) ? {2'b00, r[2:0]} : r[7:3];
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Encodes a random program and executes it in order on the model
    task automatic build_program();
        logic [31:0] r, r2, a, b, res;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        int          kind;
        int          op;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) prog[i] = '0;   // Tail stays zero words
        for (int i = 0; i < PROG_LEN; i++) begin
            r    = next_rand();
            r2   = next_rand();
            kind = int'(r[31:24] % 8'd21);
            rd   = pick_reg(r);
            rs1  = pick_reg(r >> 8);
            rs2  = pick_reg(r >> 16);
            imm  = r2[11:0];
            a    = model_regs[rs1];
            if (kind < 10) begin
                op      = kind;
                b       = model_regs[rs2];
                prog[i] = {(op == 1 || op == 7) ? 7'b0100000 : 7'b0000000,
                           rs2, rs1, F3_OF[op], rd, 7'b0110011};
            end else if (kind < 19) begin
                op = I_OP[kind-10];
                if (op == 2 || op == 6 || op == 7) begin
                    imm = {(op == 7) ? 7'b0100000 : 7'b0000000, r2[4:0]};   // Shift amount
                end
                b       = {{20{imm[11]}}, imm};
                prog[i] = {imm, rs1, F3_OF[op], rd, 7'b0010011};
            end else if (kind == 19) begin
                op      = 10;                                              // LUI
                b       = {r2[31:12], 12'b0};
                prog[i] = {r2[31:12], rd, 7'b0110111};
            end else begin
                op      = 11;
                b       = '0;
                prog[i] = '0;
            end
            case (op)
                0:       res = a + b;
                1:       res = a - b;
                2:       res = a << b[4:0];
                3:       res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                4:       res = (a < b) ? 32'd1 : 32'd0;
                5:       res = a ^ b;
                6:       res = a >> b[4:0];
                7:       res = $signed(a) >>> b[4:0];
                8:       res = a | b;
                9:       res = a & b;
                default: res = b;
            endcase
            if (op != 11 && rd != 5'd0) model_regs[rd] = res;
        end
    endtask

    task automatic apply_reset();
        i_rst = 1'b1;
        repeat (RST_CYCLES) step();
        i_rst = 1'b0;
    endtask

    task automatic load_program();
        i_en = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            i_imem_wen   = 1'b1;
            i_imem_waddr = 6'(i);
            i_imem_data  = prog[i];
            step();
        end
        i_imem_wen = 1'b0;
    endtask

    // PC is checked after every edge against the count of enabled edges
    task automatic run_program(input string name, input logic with_freeze);
        logic [31:0] r;
        int          enabled = 0;
        int          frozen = 0;
        while (enabled < RUN_CYCLES) begin
            r    = next_rand();
            i_en = !(with_freeze && r[17:16] == 2'b00 && frozen < FREEZE_MAX);
            if (i_en) enabled++;
            else frozen++;
            step();
            checks++;
            if (o_pc !== 32'(4 * enabled)) begin
                errors++;
                $display("CHECK FAILED %s pc: expected %h, actual %h",
                         name, 32'(4 * enabled), o_pc);
            end
        end
        i_en = 1'b0;
    endtask

    task automatic check_regs(input string name, input logic expect_zero);
        logic [31:0] want;
        for (int i = 0; i < 32; i++) begin
            i_dbg_rd   = 1'b1;
            i_dbg_addr = 5'(i);
            step();                                   // Debug data is registered
            want = expect_zero ? 32'd0 : model_regs[i];
            checks++;
            if (o_dbg_data !== want) begin
                errors++;
                $display("CHECK FAILED %s x%0d: expected %h, actual %h",
                         name, i, want, o_dbg_data);
            end
        end
        i_dbg_rd = 1'b0;
    endtask

    initial begin
        i_rst        = 1'b1;
        i_en         = 1'b0;
        i_imem_wen   = 1'b0;
        i_imem_waddr = '0;
        i_imem_data  = '0;
        i_dbg_rd     = 1'b0;
        i_dbg_addr   = '0;
        build_program();
        apply_reset();
        load_program();
        run_program("run", 1'b0);
        check_regs("run", 1'b0);
        apply_reset();                                // Instruction memory keeps the program
        checks++;
        if (o_pc !== 32'd0) begin
            errors++;
            $display("CHECK FAILED reset pc: expected %h, actual %h", 32'd0, o_pc);
        end
        checks++;
        if (o_dbg_data !== 32'd0) begin
            errors++;
            $display("CHECK FAILED reset dbg: expected %h, actual %h", 32'd0, o_dbg_data);
        end
        check_regs("reset", 1'b1);                    // Registers held the first run until here
        run_program("freeze", 1'b1);
        check_regs("freeze", 1'b0);
        errors += dut.u_chk.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
source/core_cfg_pkg.sv
source/rv_isa_pkg.sv
source/id_ex_if.sv
source/fetch_unit.sv
source/int_regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu_core.sv
tb/cpu_core_chk.sv
tb/cpu_core_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the RV32I pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module cpu_core_tb -o cpu_core_sim
status=0
output=$(./obj_dir/cpu_core_sim) || status=$?
echo "$output"
if [ "$status" -eq 0 ] && echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
